/* verification/program_input.hex */
// Entries 0-31: instruction words for addresses 0x00-0x7C, four per line (ISR at 0, main at 0x2C)
// Entry 32: irq cycle after reset, entry 33: write count N, then N pairs of address and data
7ffff537 7ff50513 7ff50513 00250513
05a00593 00b53023 30200073 00000013
00000013 00000013 00000013 123450b7
67808093 80000137 10010113 00113023
00013423 00500013 00013823 fff00193
00313c23 ffe18193 02313023 00108093
001080b3 fe113c23 00000013 00000013
00000013 00000013 00000013 00000013
// irq cycle, write count
000000000000000a 0000000000000007
// Expected writes, address then data
ffffffff80000100 0000000012345678
ffffffff80000108 0000000000000000
ffffffff80000110 0000000000000000
0000000080000000 000000000000005a
ffffffff80000118 ffffffffffffffff
ffffffff80000120 fffffffffffffffd
ffffffff800000f8 0000000012345679

/* build.f */
src/rv_pkg.sv
src/regfile_if.sv
src/core_ctrl.sv
src/pc_counter.sv
src/reg_file.sv
src/exec_unit.sv
src/rv_core_top.sv
verification/rv_core_sva.sv
verification/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TB FAILED
TIMESCALE ?= --timescale 1ns/1ns
VFLAGS    ?= --binary --timing --assert -j 0 $(TIMESCALE)
RTL_SRCS  ?= $(shell grep '^src/' $(FILELIST))

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall $(TIMESCALE) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_rv_core.sv */
`timescale 1ns/1ns
module tb_rv_core;
    import rv_pkg::*;

    localparam addr_t  RESET_PC    = 32'd44;
    localparam addr_t  TRAP_VECTOR = 32'd0;
    localparam int     IMEM_WORDS  = 32;            // Entries 0 to 31 of the data file
    localparam int     MAX_WAIT    = 200;           // Cycle limit for each wait loop
    localparam int     IDLE_CYCLES = 20;
    localparam instr_t IDLE_WORD   = 32'h0000_0013; // addi x0, x0, 0

    logic   clk;
    logic   reset;
    instr_t instruction;
    logic   irq;
    addr_t  pc;
    logic   heartbeat;
    logic   interrupt_pending;
    logic   interrupt_done;
    xlen_t  bus_address;
    xlen_t  bus_write_data;
    logic   bus_write_enable;

    xlen_t stim [64];               // Program, irq cycle, write count, address/data pairs
    int    irq_cycle;
    int    write_total;
    int    write_seen = 0;          // Advanced by the monitor only
    logic  monitor_on = 1'b0;
    logic  exp_heartbeat = 1'b0;    // Model, starts from the reset value
    addr_t resume_pc;               // Address MRET must come back to
    int    cycle;
    int    waited;

    rv_core_top #(
        .RESET_PC    (RESET_PC),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) rv_core_top_inst (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .irq               (irq),
        .pc                (pc),
        .heartbeat         (heartbeat),
        .interrupt_pending (interrupt_pending),
        .interrupt_done    (interrupt_done),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction memory, one word per pc/4
    always_comb begin
        if (pc < 32'(IMEM_WORDS * 4))
            instruction = stim[pc[6:2]][31:0];
        else
            instruction = IDLE_WORD;   // Past the program end
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp)
            fail_stop($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            fail_stop($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_stop($sformatf("Error: %s got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Mid-cycle monitor for heartbeat and the store stream
    always @(negedge clk) begin
        if (monitor_on) begin
            exp_heartbeat = ~exp_heartbeat;   // One toggle per active edge
            check_bit("heartbeat", heartbeat, exp_heartbeat);
            if (bus_write_enable) begin
                if (write_seen >= write_total)
                    fail_stop("Bus write seen after all expected writes");
                check_xlen("bus_address", bus_address, stim[34 + 2 * write_seen]);
                check_xlen("bus_write_data", bus_write_data, stim[35 + 2 * write_seen]);
                write_seen <= write_seen + 1;
            end
        end
    end

    initial begin
        reset = 1'b0;
        irq   = 1'b0;
        $readmemh("verification/program_input.hex", stim);
        irq_cycle   = int'(stim[32]);
        write_total = int'(stim[33]);
        // Word latched on the irq edge sits in execute when the trap is taken
        resume_pc = RESET_PC + addr_t'(4 * (irq_cycle - 1));

        repeat (4) @(posedge clk);
        reset <= 1'b1;

        // Reset values before the first active edge
        @(negedge clk);
        check_addr("pc", pc, RESET_PC);
        check_bit("bus_write_enable", bus_write_enable, 1'b0);
        check_bit("interrupt_pending", interrupt_pending, 1'b0);
        check_bit("interrupt_done", interrupt_done, 1'b0);
        check_bit("heartbeat", heartbeat, 1'b0);
        monitor_on <= 1'b1;

        cycle = 0;
        while (cycle < irq_cycle) begin   // Active edges after reset
            @(posedge clk);
            cycle++;
            if (cycle > MAX_WAIT)
                fail_stop("Timeout before the irq cycle was reached");
        end
        irq <= 1'b1;

        // Trap taken on the very next edge
        @(posedge clk);
        @(negedge clk);
        check_bit("interrupt_pending", interrupt_pending, 1'b1);
        check_addr("pc", pc, TRAP_VECTOR);
        @(posedge clk);
        irq <= 1'b0;   // Pending seen

        waited = 0;
        while (interrupt_done !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > MAX_WAIT)
                fail_stop("Timeout waiting for interrupt_done after the ISR");
        end
        check_bit("interrupt_pending", interrupt_pending, 1'b0);
        check_addr("pc", pc, resume_pc);   // Back at the squashed word
        @(negedge clk);
        check_bit("interrupt_done", interrupt_done, 1'b0);

        waited = 0;
        while (write_seen < write_total) begin
            @(negedge clk);
            waited++;
            if (waited > MAX_WAIT)
                fail_stop("Timeout waiting for the expected bus writes");
        end

        // Quiet window, any late write trips the monitor
        repeat (IDLE_CYCLES) @(negedge clk);
        @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* verification/rv_core_sva.sv */
`timescale 1ns/1ns
module rv_core_sva #(
    parameter rv_pkg::addr_t TRAP_VECTOR = 32'd0
) (
    input logic                clk,
    input logic                reset,
    input rv_pkg::addr_t       pc,
    input logic                interrupt_pending,
    input logic                interrupt_done,
    input logic                bus_write_enable,
    input rv_pkg::ctrl_state_e ctrl_state
);
    import rv_pkg::*;

    // The word in execute on trap entry never reaches the bus
    a_trap_squash: assert property (@(posedge clk) disable iff (!reset)
        $rose(interrupt_pending) |-> !bus_write_enable)
        else $error("Bus write from the word squashed by the trap");

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_done |=> !interrupt_done)
        else $error("interrupt_done longer than one cycle");

    // Trap entry redirects fetch and opens the bubble
    a_trap_redirect: assert property (@(posedge clk) disable iff (!reset)
        $rose(interrupt_pending) |-> (pc == TRAP_VECTOR) && (ctrl_state == FLUSH))
        else $error("pc 0x%h not at trap vector on interrupt entry", pc);

endmodule

bind rv_core_top rv_core_sva #(
    .TRAP_VECTOR (TRAP_VECTOR)
) rv_core_sva_inst (
    .clk               (clk),
    .reset             (reset),
    .pc                (pc),
    .interrupt_pending (interrupt_pending),
    .interrupt_done    (interrupt_done),
    .bus_write_enable  (bus_write_enable),
    .ctrl_state        (core_ctrl_inst.state)
);

/* src/rv_core_top.sv */
`timescale 1ns/1ns
module rv_core_top #(
    parameter rv_pkg::addr_t RESET_PC    = 32'd44,
    parameter rv_pkg::addr_t TRAP_VECTOR = 32'd0
) (
    input  logic           clk,
    input  logic           reset,
    input  rv_pkg::instr_t instruction,
    input  logic           irq,
    output rv_pkg::addr_t  pc,
    output logic           heartbeat,
    output logic           interrupt_pending,
    output logic           interrupt_done,
    output rv_pkg::xlen_t  bus_address,
    output rv_pkg::xlen_t  bus_write_data,
    output logic           bus_write_enable
);
    import rv_pkg::*;

    // Control between blocks
    logic  take_trap;
    logic  do_return;
    logic  squash;
    logic  is_mret;
    addr_t exec_pc;   // Address of the word in execute

    regfile_if rf_if ();

    core_ctrl core_ctrl_inst (
        .clk               (clk),
        .reset             (reset),
        .irq               (irq),
        .is_mret           (is_mret),
        .take_trap         (take_trap),
        .do_return         (do_return),
        .squash            (squash),
        .interrupt_pending (interrupt_pending),
        .interrupt_done    (interrupt_done),
        .heartbeat         (heartbeat)
    );

    pc_counter #(
        .RESET_PC    (RESET_PC),
        .TRAP_VECTOR (TRAP_VECTOR)
    ) pc_counter_inst (
        .clk       (clk),
        .reset     (reset),
        .take_trap (take_trap),
        .do_return (do_return),
        .pc        (pc),
        .exec_pc   (exec_pc)
    );

    reg_file reg_file_inst (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_if.rf)
    );

    exec_unit exec_unit_inst (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .squash           (squash),
        .is_mret          (is_mret),
        .rf               (rf_if.exec),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable)
    );

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ns
module exec_unit (
    input  logic           clk,
    input  logic           reset,
    input  rv_pkg::instr_t instruction,
    input  logic           squash,
    output logic           is_mret,
    regfile_if.exec        rf,
    output rv_pkg::xlen_t  bus_address,
    output rv_pkg::xlen_t  bus_write_data,
    output logic           bus_write_enable
);
    import rv_pkg::*;

    instr_t     ir;        // Word waiting in execute
    logic [6:0] opcode;
    logic [2:0] funct3;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    logic       is_lui;
    logic       is_addi;
    logic       is_sd;
    xlen_t      store_addr;

    // Fetch stage, word for the current pc
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            ir <= NOP_WORD;
        else
            ir <= instruction;
    end

    // Field decode
    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    // Immediates, all sign extended to 64 bits
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};   // LUI

    // Supported instructions, anything else is a no-op
    assign is_lui  = (opcode == OPC_LUI);
    assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == F3_ADDI);
    assign is_sd   = (opcode == OPC_STORE) && (funct3 == F3_SD);
    assign is_mret = (ir == INSTR_MRET) && !squash;   // Return request to controller

    // Register file read indices straight from the word
    assign rf.rs1_idx = ir[19:15];
    assign rf.rs2_idx = ir[24:20];

    // Writeback for LUI and ADDI
    assign rf.rd_idx  = ir[11:7];
    assign rf.rd_we   = (is_lui || is_addi) && !squash;
    assign rf.rd_data = is_lui ? imm_u : (rf.rs1_data + imm_i);

    assign store_addr = rf.rs1_data + imm_s;

    // Store strobe, one cycle per executed SD
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            bus_write_enable <= 1'b0;
        else
            bus_write_enable <= is_sd && !squash;
    end

    // Address and data hold until the next store
    always_ff @(posedge clk) begin
        if (is_sd && !squash) begin
            bus_address    <= store_addr;
            bus_write_data <= rf.rs2_data;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns
module reg_file (
    input logic   clk,
    input logic   reset,
    regfile_if.rf rf
);
    import rv_pkg::*;

    xlen_t regs [REG_COUNT];

    // Combinational reads, x0 forced to zero
    always_comb begin
        if (rf.rs1_idx == '0)
            rf.rs1_data = '0;
        else
            rf.rs1_data = regs[rf.rs1_idx];
    end

    always_comb begin
        if (rf.rs2_idx == '0)
            rf.rs2_data = '0;
        else
            rf.rs2_data = regs[rf.rs2_idx];
    end

    // Single write port
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;               // Whole array cleared
        end else if (rf.rd_we && (rf.rd_idx != '0)) begin
            regs[rf.rd_idx] <= rf.rd_data;   // Writes to x0 dropped
        end
    end

endmodule

/* src/pc_counter.sv */
`timescale 1ns/1ns
module pc_counter #(
    parameter rv_pkg::addr_t RESET_PC    = 32'd44,
    parameter rv_pkg::addr_t TRAP_VECTOR = 32'd0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          take_trap,
    input  logic          do_return,
    output rv_pkg::addr_t pc,
    output rv_pkg::addr_t exec_pc
);
    import rv_pkg::*;

    addr_t mepc;       // Resume address for MRET
    addr_t pc_next;

    // Next fetch address, trap first, then return, else sequential
    always_comb begin
        if (take_trap)
            pc_next = TRAP_VECTOR;
        else if (do_return)
            pc_next = mepc;
        else
            pc_next = pc + 32'd4;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc      <= RESET_PC;
            exec_pc <= RESET_PC;   // First word at RESET_PC must survive an early trap
        end else begin
            pc      <= pc_next;
            exec_pc <= pc;         // Follows the word into the latch
        end
    end

    // Saved address of the word squashed by the trap
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            mepc <= RESET_PC;
        else if (take_trap)
            mepc <= exec_pc;
    end

endmodule

/* src/core_ctrl.sv */
`timescale 1ns/1ns
module core_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic irq,
    input  logic is_mret,
    output logic take_trap,
    output logic do_return,
    output logic squash,
    output logic interrupt_pending,
    output logic interrupt_done,
    output logic heartbeat
);
    import rv_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    // Trap wins over everything else
    assign take_trap = irq && !interrupt_pending;
    assign do_return = is_mret && !take_trap;   // MRET only when no trap this cycle

    // Kill the execute word in the bubble cycle and on trap entry
    assign squash = (state == FLUSH) || take_trap;

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (take_trap || do_return)
                    state_next = FLUSH;   // Redirect, wrong-path word follows
            end
            FLUSH: begin
                // is_mret is squashed here, only a trap can redirect again
                state_next = take_trap ? FLUSH : RUN;
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state             <= RUN;
            interrupt_pending <= 1'b0;
            interrupt_done    <= 1'b0;
            heartbeat         <= 1'b0;
        end else begin
            state     <= state_next;
            heartbeat <= ~heartbeat;       // Alive indicator

            // Pending flag set on entry, cleared by MRET
            if (take_trap)
                interrupt_pending <= 1'b1;
            else if (do_return)
                interrupt_pending <= 1'b0;

            interrupt_done <= do_return;   // Single cycle pulse after return
        end
    end

endmodule

/* src/regfile_if.sv */
`timescale 1ns/1ns
interface regfile_if;
    import rv_pkg::*;

    // Read side, combinational
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    // Write side, lands on the clock edge
    reg_idx_t rd_idx;
    logic     rd_we;
    xlen_t    rd_data;

    // Execute stage view
    modport exec (
        output rs1_idx, rs2_idx,
        output rd_idx, rd_we, rd_data,
        input  rs1_data, rs2_data
    );

    // Register array view
    modport rf (
        input  rs1_idx, rs2_idx,
        input  rd_idx, rd_we, rd_data,
        output rs1_data, rs2_data
    );

endinterface

/* src/rv_pkg.sv */
package rv_pkg;

    // Datapath widths
    localparam int XLEN      = 64;
    localparam int ADDR_W    = 32;   // Program counter only
    localparam int ILEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]   xlen_t;    // Register and bus data
    typedef logic [ADDR_W-1:0] addr_t;    // Fetch address
    typedef logic [ILEN-1:0]   instr_t;
    typedef logic [4:0]        reg_idx_t;

    // Major opcodes, bits [6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // Funct3 selectors, bits [14:12]
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_SD   = 3'b011;   // 64-bit store

    // MRET matched as a whole word
    // funct12 0x302, SYSTEM opcode, all other fields zero
    localparam instr_t INSTR_MRET = 32'h3020_0073;

    // Latch reset value, addi x0, x0, 0
    localparam instr_t NOP_WORD = 32'h0000_0013;

    // Controller states
    typedef enum logic [0:0] {
        RUN   = 1'b0,   // Normal issue
        FLUSH = 1'b1    // Drop the word fetched on the old path
    } ctrl_state_e;

endpackage
